// File: sim.f
verilog/fp64_pkg.sv
verilog/fp64_decomp.sv
verilog/fp64_compare.sv
verilog/fp_cmp_result.sv
verilog/fp_cmp_cfg.sv
verilog/fp_cmp_unit.sv
testbench/tb_fp_cmp_unit.sv

// File: Makefile
# Verilator build and run of the compare unit testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_fp_cmp_unit
FILELIST  := sim.f
BUILD_DIR := obj_dir
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/fp_cmp_tests.txt
# cmp lines: name cmp a b expected_vector pred invalid snan flags (flags hex: bit1 invalid, bit0 snan)
# cfg lines: name cfg pred_sel clr_flags
pos_lt         cmp 3FF0000000000000 4000000000000000 110E 0 0 0 0
pos_gt         cmp 4008000000000000 3FF8000000000000 1F00 0 0 0 0
pos_eq         cmp 3FF8000000000000 3FF8000000000000 1A05 1 0 0 0
neg_lt         cmp C000000000000000 BFF0000000000000 1906 0 0 0 0
neg_gt         cmp BFF0000000000000 C000000000000000 1708 0 0 0 0
mix_lt         cmp BFF0000000000000 4000000000000000 110E 0 0 0 0
mix_gt         cmp 4008000000000000 BFF0000000000000 1F00 0 0 0 0
pzero_nzero    cmp 0000000000000000 8000000000000000 1A05 1 0 0 0
nzero_pzero    cmp 8000000000000000 0000000000000000 1A05 1 0 0 0
denorm_gt_zero cmp 0000000000000001 0000000000000000 1F00 0 0 0 0
sel_gt         cfg A 0
gt_true        cmp 4000000000000000 3FF0000000000000 1F00 1 0 0 0
gt_false_eq    cmp 3FF0000000000000 3FF0000000000000 1A05 0 0 0 0
qnan_a         cmp 7FF8000000000000 3FF0000000000000 0910 0 1 0 2
qnan_b         cmp 3FF0000000000000 7FF8000000000000 0118 0 1 0 2
after_nan_ok   cmp 3FF0000000000000 4000000000000000 110E 0 0 0 2
sel_ord        cfg C 0
snan_a         cmp 7FF0000000000001 3FF0000000000000 0910 0 1 1 3
ord_true       cmp 3FF0000000000000 4000000000000000 110E 1 0 0 3
clear_flags    cfg C 1
after_clear    cmp 4000000000000000 3FF0000000000000 1F00 1 0 0 0
inf_inf        cmp 7FF0000000000000 7FF0000000000000 120D 1 1 0 2
ninf_pinf      cmp FFF0000000000000 7FF0000000000000 110E 1 1 0 2
sel_maglt      cfg 3 0
mag_lt_unlike  cmp C008000000000000 3FF0000000000000 1906 0 0 0 2
mag_lt_neg_b   cmp 3FF0000000000000 C008000000000000 1708 1 0 0 2
mag_lt_binf    cmp 3FF0000000000000 FFF0000000000000 1708 1 0 0 2
mag_ainf       cmp 7FF0000000000000 3FF0000000000000 1F00 0 0 0 2
sel_unord      cfg 4 1
unord_qnan     cmp 3FF0000000000000 7FF8000000000000 0118 1 1 0 2
snan_b         cmp 4000000000000000 7FF0000000000001 0118 1 1 1 3
unord_false    cmp 3FF0000000000000 3FF0000000000000 1A05 0 0 0 3
sel_eq         cfg 0 1
eq_after       cmp 4000000000000000 4000000000000000 1A05 1 0 0 0

// File: testbench/tb_fp_cmp_unit.sv
// testbench for the double-precision compare unit
// reads one test per line from testbench/fp_cmp_tests.txt,
// cmp lines strobe two operands and check vector, pred, exc and flags,
// cfg lines write the predicate select and may clear the sticky flags
// prints one line per test and a closing count line

`timescale 1ns/10ps

module tb_fp_cmp_unit;

	localparam int NAME_W  = 8 * 24;
	localparam int LINE_W  = 8 * 256;
	localparam int TIMEOUT = 10;

	logic                  clk;
	logic                  rst_n;
	logic                  in_valid;
	fp64_pkg::fp64_u       a;
	fp64_pkg::fp64_u       b;
	logic                  cfg_we;
	fp64_pkg::fp_cmp_cfg_t cfg_wdata;
	logic                  out_valid;
	fp64_pkg::fp_cmp_vec_t result;
	logic                  pred;
	fp64_pkg::fp_cmp_exc_t exc;
	fp64_pkg::fp_cmp_exc_t flags;

	int pass_cnt;
	int fail_cnt;
	int test_err;

	fp_cmp_unit dut_i
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.cfg_we    (cfg_we),
		.cfg_wdata (cfg_wdata),
		.out_valid (out_valid),
		.result    (result),
		.pred      (pred),
		.exc       (exc),
		.flags     (flags)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	// ====================
	// helpers
	// ====================
	// inputs change 2 ns after the rising edge, outputs are sampled there too
	task automatic next_edge();
		@(posedge clk);
		#2;
	endtask

	task automatic check_value(input logic [NAME_W-1:0] name, input logic [8*8-1:0] what,
		input logic [15:0] expected, input logic [15:0] actual);
		assert (actual === expected)
		else
		begin
			$display("MISMATCH %0s %0s expected %0h actual %0h", name, what, expected, actual);
			test_err++;
		end
	endtask

	task automatic report_test(input logic [NAME_W-1:0] name);
		if (test_err == 0)
		begin
			$display("PASS %0s", name);
			pass_cnt++;
		end
		else
		begin
			$display("FAIL %0s", name);
			fail_cnt++;
		end
		test_err = 0;
	endtask

	// one comparison: strobe for a cycle, wait for the result pulse
	task automatic run_cmp(input logic [NAME_W-1:0] name, input logic [63:0] op_a,
		input logic [63:0] op_b, input logic [15:0] exp_vec, input logic exp_pred,
		input logic exp_inv, input logic exp_snan, input logic [1:0] exp_flags);
		int wait_cnt;
		next_edge();
		in_valid = 1'b1;
		a.raw    = op_a;
		b.raw    = op_b;
		next_edge();
		in_valid = 1'b0;
		wait_cnt = 0;
		while (!out_valid && wait_cnt < TIMEOUT)
		begin
			next_edge();
			wait_cnt++;
		end
		if (!out_valid)
		begin
			$display("%0s: out_valid never came after the operand strobe", name);
			test_err++;
		end
		else
		begin
			check_value(name, "result", exp_vec, result);
			check_value(name, "pred", {15'd0, exp_pred}, {15'd0, pred});
			check_value(name, "exc", {14'd0, exp_inv, exp_snan}, {14'd0, exc});
			// sticky flags pick up this result one edge later
			next_edge();
			check_value(name, "flags", {14'd0, exp_flags}, {14'd0, flags});
			assert (!out_valid)
			else
			begin
				$display("%0s: out_valid stayed high for more than one cycle", name);
				test_err++;
			end
		end
		report_test(name);
	endtask

	task automatic write_cfg(input logic [NAME_W-1:0] name, input logic [3:0] sel,
		input logic clr);
		next_edge();
		cfg_we              = 1'b1;
		cfg_wdata.pred_sel  = sel;
		cfg_wdata.clr_flags = clr;
		next_edge();
		cfg_we = 1'b0;
		// a clear shows as zero flags right after the write edge
		if (clr)
			check_value(name, "flags", 16'd0, {14'd0, flags});
		report_test(name);
	endtask

	// ====================
	// main sequence
	// ====================
	initial
	begin
		int                fd;
		int                n;
		logic [LINE_W-1:0] line;
		logic [NAME_W-1:0] name;
		logic [23:0]       kind;
		logic [63:0]       op_a;
		logic [63:0]       op_b;
		logic [15:0]       exp_vec;
		logic              exp_pred;
		logic              exp_inv;
		logic              exp_snan;
		logic [1:0]        exp_flags;
		logic [3:0]        sel;
		logic              clr;

		clk       = 1'b0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		a         = '0;
		b         = '0;
		cfg_we    = 1'b0;
		cfg_wdata = '0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		test_err  = 0;

		// reset held for 3 cycles
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_value("reset_state", "valid", 16'd0, {15'd0, out_valid});
		check_value("reset_state", "result", 16'd0, result);
		check_value("reset_state", "pred", 16'd0, {15'd0, pred});
		check_value("reset_state", "flags", 16'd0, {14'd0, flags});
		report_test("reset_state");

		fd = $fopen("testbench/fp_cmp_tests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test file testbench/fp_cmp_tests.txt");
			fail_cnt++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = '0;
				name = '0;
				kind = '0;
				n    = $fgets(line, fd);
				if (n > 0)
					n = $sscanf(line, "%s %s", name, kind);
				// blank lines and # comments are skipped
				if (n >= 2 && name != {{(NAME_W - 8){1'b0}}, "#"})
				begin
					if (kind == "cmp")
					begin
						n = $sscanf(line, "%s %s %h %h %h %h %h %h %h", name, kind, op_a,
							op_b, exp_vec, exp_pred, exp_inv, exp_snan, exp_flags);
						if (n == 9)
							run_cmp(name, op_a, op_b, exp_vec, exp_pred, exp_inv,
								exp_snan, exp_flags);
						else
						begin
							$display("%0s: cmp line has the wrong number of fields", name);
							fail_cnt++;
						end
					end
					else if (kind == "cfg")
					begin
						n = $sscanf(line, "%s %s %h %h", name, kind, sel, clr);
						if (n == 4)
							write_cfg(name, sel, clr);
						else
						begin
							$display("%0s: cfg line has the wrong number of fields", name);
							fail_cnt++;
						end
					end
					else
					begin
						$display("%0s: unknown test kind in the test file", name);
						fail_cnt++;
					end
				end
			end
			$fclose(fd);
		end

		$display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && pass_cnt > 1)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: verilog/fp_cmp_unit.sv
// top level of the double-precision compare unit
// operands strobed in cycle N give a registered result in cycle N+1,
// one comparison may start every cycle
// pred is the result bit chosen by the configured predicate select

`timescale 1ns/10ps

module fp_cmp_unit
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  fp64_pkg::fp64_u       a,
	input  fp64_pkg::fp64_u       b,
	input  logic                  cfg_we,
	input  fp64_pkg::fp_cmp_cfg_t cfg_wdata,
	output logic                  out_valid,
	output fp64_pkg::fp_cmp_vec_t result,
	output logic                  pred,
	output fp64_pkg::fp_cmp_exc_t exc,
	output fp64_pkg::fp_cmp_exc_t flags
);

	fp64_pkg::fp64_class_t           cls_a;
	fp64_pkg::fp64_class_t           cls_b;
	fp64_pkg::fp_cmp_vec_t           vec_d;
	fp64_pkg::fp_cmp_exc_t           exc_d;
	logic [fp64_pkg::PRED_SEL_W-1:0] pred_sel;

	// ====================
	// decode and compare
	// ====================
	fp64_decomp decomp_a_i (.i(a), .cls(cls_a));
	fp64_decomp decomp_b_i (.i(b), .cls(cls_b));

	fp64_compare compare_i
	(
		.a   (a),
		.b   (b),
		.ca  (cls_a),
		.cb  (cls_b),
		.vec (vec_d),
		.exc (exc_d)
	);

	// registered result and condition select
	fp_cmp_result result_i
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.vec_d     (vec_d),
		.exc_d     (exc_d),
		.pred_sel  (pred_sel),
		.out_valid (out_valid),
		.result    (result),
		.exc       (exc),
		.pred      (pred)
	);

	// sticky flags take the registered exceptions
	fp_cmp_cfg cfg_i
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_we    (cfg_we),
		.cfg_wdata (cfg_wdata),
		.res_valid (out_valid),
		.res_exc   (exc),
		.pred_sel  (pred_sel),
		.flags     (flags)
	);

endmodule

// File: verilog/fp_cmp_cfg.sv
// configuration register beside the output stage
// stores the predicate select on a write and keeps sticky
// invalid / signalling-NaN flags until software clears them

`timescale 1ns/10ps

module fp_cmp_cfg
(
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                cfg_we,
	input  fp64_pkg::fp_cmp_cfg_t               cfg_wdata,
	input  logic                                res_valid,
	input  fp64_pkg::fp_cmp_exc_t               res_exc,
	output logic [fp64_pkg::PRED_SEL_W-1:0]     pred_sel,
	output fp64_pkg::fp_cmp_exc_t               flags
);

	logic clr;

	// clear request only counts on a write strobe
	assign clr = cfg_we & cfg_wdata.clr_flags;

	// ====================
	// predicate select
	// ====================
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pred_sel <= '0;
		else if (cfg_we)
			pred_sel <= cfg_wdata.pred_sel;
	end

	// sticky flags, clear beats a same-edge set
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			flags <= '0;
		else if (clr)
			flags <= '0;
		else if (res_valid)
			flags <= flags | res_exc;
	end

endmodule

// File: verilog/fp_cmp_result.sv
// output stage of the compare unit
// registers the predicate vector and exceptions on the input strobe,
// pulses out_valid for one cycle and picks the branch condition bit
// from the registered vector with the current predicate select

`timescale 1ns/10ps

module fp_cmp_result
(
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                in_valid,
	input  fp64_pkg::fp_cmp_vec_t               vec_d,
	input  fp64_pkg::fp_cmp_exc_t               exc_d,
	input  logic [fp64_pkg::PRED_SEL_W-1:0]     pred_sel,
	output logic                                out_valid,
	output fp64_pkg::fp_cmp_vec_t               result,
	output fp64_pkg::fp_cmp_exc_t               exc,
	output logic                                pred
);

	logic [15:0] result_bits;

	// ====================
	// pipeline register
	// ====================
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			result    <= '0;
			exc       <= '0;
		end
		else
		begin
			// one-cycle pulse per strobe
			out_valid <= in_valid;
			// hold the last result until a new strobe arrives
			if (in_valid)
			begin
				result <= vec_d;
				exc    <= exc_d;
			end
		end
	end

	// condition bit follows pred_sel without another register stage
	assign result_bits = result;
	assign pred        = result_bits[pred_sel];

endmodule

// File: verilog/fp64_compare.sv
// combinational compare of two decomposed double-precision operands
// produces the 16-bit predicate vector and the per-result exceptions
// raw words are used for bit equality, class structs for the ordering

`timescale 1ns/10ps

module fp64_compare
(
	input  fp64_pkg::fp64_u       a,
	input  fp64_pkg::fp64_u       b,
	input  fp64_pkg::fp64_class_t ca,
	input  fp64_pkg::fp64_class_t cb,
	output fp64_pkg::fp_cmp_vec_t vec,
	output fp64_pkg::fp_cmp_exc_t exc
);

	logic unord;
	logic both_zero;
	logic same_val;
	logic eq;
	logic mag_lt_raw;
	logic mag_gt;
	logic mag_lt;
	logic lt;

	// ====================
	// ordering
	// ====================
	assign unord     = ca.nan | cb.nan;
	assign both_zero = ca.zero & cb.zero;

	// +0 and -0 compare equal despite differing sign bits
	assign same_val = (a.raw == b.raw) | both_zero;
	assign eq       = same_val & ~unord;

	// magnitude from exponent and mantissa, b infinite forces a smaller
	assign mag_lt_raw = ({ca.exp, ca.man} < {cb.exp, cb.man}) | cb.inf;

	// strict magnitude order, an infinite side wins only against finite
	assign mag_gt = ({ca.exp, ca.man} > {cb.exp, cb.man}) | (ca.inf & ~cb.inf);
	assign mag_lt = ({ca.exp, ca.man} < {cb.exp, cb.man}) | (cb.inf & ~ca.inf);

	// unlike signs: negative side is less unless both are zero
	// like signs: magnitude order, flipped when both negative
	assign lt = (ca.sgn ^ cb.sgn) ? (ca.sgn & ~both_zero) :
		ca.sgn ? mag_gt : mag_lt;

	// ====================
	// result vector
	// ====================
	always_comb
	begin
		vec         = '0;
		vec.eq      = eq;
		vec.lt      = lt & ~unord;
		vec.le      = (lt | eq) & ~unord;
		vec.mag_lt  = mag_lt_raw;
		vec.unord   = unord;
		// complements, ordered ones still masked by unordered
		vec.ne      = ~eq;
		vec.ge      = ~lt & ~unord;
		vec.gt      = ~(lt | eq) & ~unord;
		vec.mag_ge  = ~mag_lt_raw;
		vec.ord     = ~unord;
	end

	// invalid also covers a pair of infinities
	assign exc.invalid = ca.nan | cb.nan | (ca.inf & cb.inf);
	assign exc.snan    = ca.snan | cb.snan;

endmodule

// File: verilog/fp64_decomp.sv
// splits one double-precision operand into its fields and classifies it
// purely combinational, one instance per comparator input

`timescale 1ns/10ps

module fp64_decomp
(
	input  fp64_pkg::fp64_u       i,
	output fp64_pkg::fp64_class_t cls
);

	logic exp_ones;
	logic exp_zero;
	logic man_zero;

	// exponent patterns that mark special values
	assign exp_ones = &i.f.exp;
	assign exp_zero = ~|i.f.exp;
	assign man_zero = ~|i.f.man;

	always_comb
	begin
		// fields pass straight through the union's field view
		cls.sgn  = i.f.sgn;
		cls.exp  = i.f.exp;
		cls.man  = i.f.man;

		// zero ignores the sign so +0 and -0 classify alike
		cls.zero = exp_zero & man_zero;
		cls.inf  = exp_ones & man_zero;
		cls.nan  = exp_ones & ~man_zero;

		// top mantissa bit tells quiet from signalling
		cls.qnan = exp_ones & ~man_zero & i.f.man[fp64_pkg::FMSB];
		cls.snan = exp_ones & ~man_zero & ~i.f.man[fp64_pkg::FMSB];
	end

endmodule

// File: verilog/fp64_pkg.sv
// shared types and constants for the double-precision compare unit
// every design file refers to these by scoped name, fp64_pkg::name
// holds the operand view, operand class, result vector and config word

package fp64_pkg;

	// ====================
	// field widths
	// ====================
	localparam int EMSB       = 10;
	localparam int FMSB       = 51;
	localparam int FP_WIDTH   = 64;
	localparam int PRED_SEL_W = 4;

	// sign / exponent / mantissa split of one operand
	typedef struct packed {
		logic            sgn;
		logic [EMSB:0]   exp;
		logic [FMSB:0]   man;
	} fp64_fields_t;

	// same word seen as raw bits for the equality test, or as fields
	typedef union packed {
		logic [FP_WIDTH-1:0] raw;
		fp64_fields_t        f;
	} fp64_u;

	// decomposed operand with its special-value class
	typedef struct packed {
		logic            sgn;
		logic [EMSB:0]   exp;
		logic [FMSB:0]   man;
		logic            zero;
		logic            inf;
		logic            nan;
		logic            qnan;
		logic            snan;
	} fp64_class_t;

	// ====================
	// result vector
	// ====================
	// low half holds the predicates, high half their complements
	typedef struct packed {
		logic [2:0] rsvd_hi;
		logic       ord;
		logic       mag_ge;
		logic       gt;
		logic       ge;
		logic       ne;
		logic [2:0] rsvd_lo;
		logic       unord;
		logic       mag_lt;
		logic       le;
		logic       lt;
		logic       eq;
	} fp_cmp_vec_t;

	// configuration word written by software
	typedef struct packed {
		logic [PRED_SEL_W-1:0] pred_sel;
		logic                  clr_flags;
	} fp_cmp_cfg_t;

	// exception pair, per result and as sticky flags
	typedef struct packed {
		logic invalid;
		logic snan;
	} fp_cmp_exc_t;

endpackage
